// ==== flist.f ====
+incdir+hw
hw/execPkg.sv
hw/resStation.sv
hw/execUnit.sv
hw/execCluster.sv
dv/execChecker.sv
dv/execClusterTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execution slice testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/10ps -f flist.f \
        --top-module execClusterTb -o simv; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== dv/execClusterTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_params.svh"

module execClusterTb;

    localparam int TotalOps = 98;   // Instructions over all six tests.
    localparam int CycleNs  = 4;
    localparam int NumTags  = 1 << `TAG_W;

    logic          clk;
    logic          rst;
    logic          rdy;
    logic          flush;
    logic          dispValid;
    execPkg::opT   dispOp;
    execPkg::addrT dispPc;
    execPkg::dataT dispImm;
    execPkg::tagT  dispTag;
    logic          src1Ready;
    execPkg::dataT src1Val;
    execPkg::tagT  src1Tag;
    logic          src2Ready;
    execPkg::dataT src2Val;
    execPkg::tagT  src2Tag;
    logic          ldValid;
    execPkg::tagT  ldTag;
    execPkg::dataT ldData;
    logic          full;
    logic          resValid;
    execPkg::tagT  resTag;
    execPkg::dataT resData;
    logic          resJump;
    execPkg::addrT resTarget;
    logic          checkFull;
    logic          expFull;
    int            outstanding;
    int            passCount;
    int            failCount;
    int            tagCount;
    int            failMark;

    execCluster dut0 (.*);

    execChecker chk0 (.*);

    always #2 clk = ~clk;

    // LUI, AUIPC, then ADDI through AND.
    function automatic execPkg::opT pickAlu(input int k);
        if (k < 2)
            return execPkg::opT'(5'(k));
        return execPkg::opT'(5'(k) + 5'd8);
    endfunction

    function automatic logic [63:0] operandPair(input int kind);
        logic [31:0] x;
        logic [31:0] y;
        x = $urandom() & 32'h3fff_ffff;
        y = x + ($urandom() & 32'h0000_ffff) + 32'd1;
        case (kind)
            0:       return {x, x};
            1:       return {x, y};
            2:       return {y, x};
            3:       return {x | 32'h8000_0000, y};   // Negative against positive.
            default: return {y, x | 32'h8000_0000};
        endcase
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic waitIdle();
        while (outstanding != 0)
            nextCycle();
    endtask

    task automatic pulseFlush();
        flush = 1'b1;
        nextCycle();
        flush = 1'b0;
        tagCount = 0;
    endtask

    task automatic takeTag(output execPkg::tagT tag);
        if (tagCount == NumTags) begin
            waitIdle();
            pulseFlush();   // Tags are reused only after a flush.
        end
        tag = execPkg::tagT'(tagCount);
        tagCount++;
    endtask

    task automatic pauseFor(input int cycles);
        rdy = 1'b0;
        repeat (cycles) nextCycle();
        rdy = 1'b1;
    endtask

    task automatic expectFull(input logic v);
        checkFull = 1'b1;
        expFull   = v;
        nextCycle();
        checkFull = 1'b0;
    endtask

    task automatic sendLoad(input execPkg::tagT tag, input execPkg::dataT data);
        ldValid = 1'b1;
        ldTag   = tag;
        ldData  = data;
        nextCycle();
        ldValid = 1'b0;
    endtask

    task automatic sendOp(input execPkg::opT op, input logic r1, input execPkg::dataT v1,
                          input execPkg::tagT w1, input logic r2, input execPkg::dataT v2,
                          input execPkg::tagT w2, output execPkg::tagT tag);
        takeTag(tag);
        while (full)
            nextCycle();
        dispValid = 1'b1;
        dispOp    = op;
        dispPc    = $urandom() & 32'hffff_fffc;
        dispImm   = $urandom();
        dispTag   = tag;
        src1Ready = r1;
        src1Val   = v1;
        src1Tag   = w1;
        src2Ready = r2;
        src2Val   = v2;
        src2Tag   = w2;
        nextCycle();
        dispValid = 1'b0;
    endtask

    task automatic endTest(input int n, input string name);
        waitIdle();
        $display("Test %0d (%s) finished with %0d errors", n, name, failCount - failMark);
        failMark = failCount;
    endtask

    initial begin
        #(TotalOps * 20 * CycleNs + 2000);
        $display("Timeout: the tests did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        execPkg::tagT t;
        execPkg::tagT p;
        execPkg::tagT x;
        execPkg::tagT ldTags [4];
        logic [63:0]  pair;
        clk       = 1'b0;
        rst       = 1'b1;
        rdy       = 1'b1;
        flush     = 1'b0;
        dispValid = 1'b0;
        dispOp    = execPkg::ADD;
        dispPc    = '0;
        dispImm   = '0;
        dispTag   = '0;
        src1Ready = 1'b0;
        src1Val   = '0;
        src1Tag   = '0;
        src2Ready = 1'b0;
        src2Val   = '0;
        src2Tag   = '0;
        ldValid   = 1'b0;
        ldTag     = '0;
        ldData    = '0;
        checkFull = 1'b0;
        expFull   = 1'b0;
        tagCount  = 0;
        failMark  = 0;
        void'($urandom(32'h8210));
        repeat (3) @(posedge clk);
        #0.5;
        rst = 1'b0;

        pulseFlush();
        for (int k = 0; k < 21; k++)
            sendOp(pickAlu(k), 1'b1, $urandom(), '0, 1'b1, $urandom(), '0, t);
        endTest(1, "independent ALU ops");

        pulseFlush();
        for (int b = 0; b < 6; b++) begin
            for (int k = 0; k < 5; k++) begin
                pair = operandPair(k);
                sendOp(execPkg::opT'(5'(b) + 5'd4), 1'b1, pair[63:32], '0,
                       1'b1, pair[31:0], '0, t);
            end
        end
        sendOp(execPkg::JAL, 1'b1, $urandom(), '0, 1'b1, $urandom(), '0, t);
        sendOp(execPkg::JALR, 1'b1, $urandom(), '0, 1'b1, $urandom(), '0, t);
        endTest(2, "control transfer");

        pulseFlush();
        repeat (3) begin
            sendOp(pickAlu($urandom_range(0, 20)), 1'b1, $urandom(), '0, 1'b1, $urandom(), '0, p);
            sendOp(pickAlu($urandom_range(0, 20)), 1'b0, '0, p, 1'b1, $urandom(), '0, x);
            // Lands in the cycle where p is on the result bus.
            sendOp(pickAlu($urandom_range(0, 20)), 1'b0, '0, p, 1'b0, '0, x, t);
            waitIdle();
        end
        endTest(3, "dependency chains");

        pulseFlush();
        for (int k = 0; k < 4; k++)
            takeTag(ldTags[k]);
        for (int k = 0; k < 4; k++)
            sendOp(pickAlu($urandom_range(0, 20)), 1'b0, '0, ldTags[k], 1'b1, $urandom(), '0, t);
        expectFull(1'b1);
        for (int k = 0; k < 4; k++) begin
            repeat ($urandom_range(1, 6)) nextCycle();
            sendLoad(ldTags[k], $urandom());
            if (k == 0) begin
                nextCycle();   // Woken entry issues, then its slot frees.
                expectFull(1'b0);
            end
        end
        endTest(4, "load wakeup");

        pulseFlush();
        for (int k = 0; k < 24; k++) begin
            if ($urandom_range(0, 2) == 0)
                pauseFor($urandom_range(1, 6));
            sendOp(pickAlu($urandom_range(0, 20)), 1'b1, $urandom(), '0, 1'b1, $urandom(), '0, t);
        end
        while (outstanding != 0) begin
            if ($urandom_range(0, 1) == 0)
                pauseFor($urandom_range(1, 4));
            else
                nextCycle();
        end
        endTest(5, "pause");

        pulseFlush();
        for (int k = 0; k < 4; k++)
            sendOp(pickAlu(k + 4), 1'b0, '0, execPkg::tagT'(12 + k), 1'b1, $urandom(), '0, t);
        expectFull(1'b1);
        repeat (3) nextCycle();
        pulseFlush();
        expectFull(1'b0);
        for (int k = 0; k < 4; k++)
            sendLoad(execPkg::tagT'(12 + k), $urandom());   // Would wake a surviving entry.
        repeat (3) nextCycle();   // A stale result would show up here.
        for (int k = 0; k < 4; k++)
            sendOp(pickAlu($urandom_range(0, 20)), 1'b1, $urandom(), '0, 1'b1, $urandom(), '0, t);
        endTest(6, "flush");

        $display("Passed checks: %0d, failed checks: %0d", passCount, failCount);
        if (failCount == 0 && passCount > 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/execChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_params.svh"

module execChecker (
    input  wire                clk,
    input  wire                rst,
    input  wire                rdy,
    input  wire                flush,
    input  wire                dispValid,
    input  wire execPkg::opT   dispOp,
    input  wire execPkg::addrT dispPc,
    input  wire execPkg::dataT dispImm,
    input  wire execPkg::tagT  dispTag,
    input  wire                src1Ready,
    input  wire execPkg::dataT src1Val,
    input  wire execPkg::tagT  src1Tag,
    input  wire                src2Ready,
    input  wire execPkg::dataT src2Val,
    input  wire execPkg::tagT  src2Tag,
    input  wire                ldValid,
    input  wire execPkg::tagT  ldTag,
    input  wire execPkg::dataT ldData,
    input  wire                full,
    input  wire                resValid,
    input  wire execPkg::tagT  resTag,
    input  wire execPkg::dataT resData,
    input  wire                resJump,
    input  wire execPkg::addrT resTarget,
    input  wire                checkFull,
    input  wire                expFull,
    output int                 outstanding,
    output int                 passCount,
    output int                 failCount
);

    localparam int NumTags = 1 << `TAG_W;

    // Shadow table, one row per rename tag.
    logic          live [NumTags];
    logic          gone [NumTags];
    execPkg::opT   opS  [NumTags];
    execPkg::addrT pcS  [NumTags];
    execPkg::dataT immS [NumTags];
    logic          aOk  [NumTags];
    logic          bOk  [NumTags];
    execPkg::dataT aV   [NumTags];
    execPkg::dataT bV   [NumTags];
    execPkg::tagT  aW   [NumTags];
    execPkg::tagT  bW   [NumTags];

    // Returns {jump, target, data}.
    function automatic logic [64:0] refExec(input execPkg::opT op, input execPkg::addrT pc,
                                            input execPkg::dataT imm, input execPkg::dataT a,
                                            input execPkg::dataT b);
        execPkg::dataT d;
        execPkg::addrT tgt;
        logic          j;
        logic [31:0]   sa;
        logic [31:0]   sb;
        logic [31:0]   si;
        sa = a ^ 32'h8000_0000;   // Signed order as unsigned order.
        sb = b ^ 32'h8000_0000;
        si = imm ^ 32'h8000_0000;
        d = '0;
        j = 1'b0;
        case (op)
            execPkg::LUI:   d = imm;
            execPkg::AUIPC: d = pc + imm;
            execPkg::JAL, execPkg::JALR: begin
                d = pc + 32'd4;
                j = 1'b1;
            end
            execPkg::BEQ:   j = a == b;
            execPkg::BNE:   j = a != b;
            execPkg::BLT:   j = sa < sb;
            execPkg::BGE:   j = !(sa < sb);
            execPkg::BLTU:  j = a < b;
            execPkg::BGEU:  j = !(a < b);
            execPkg::ADDI:  d = a + imm;
            execPkg::SLTI:  d = 32'(sa < si);
            execPkg::SLTIU: d = 32'(a < imm);
            execPkg::XORI:  d = a ^ imm;
            execPkg::ORI:   d = a | imm;
            execPkg::ANDI:  d = a & imm;
            execPkg::SLLI:  d = a << imm[4:0];
            execPkg::SRLI:  d = a >> imm[4:0];
            execPkg::SRAI:  d = (a >> imm[4:0]) | (a[31] ? ~(32'hffff_ffff >> imm[4:0]) : '0);
            execPkg::ADD:   d = a + b;
            execPkg::SUB:   d = a - b;
            execPkg::SLL:   d = a << b[4:0];
            execPkg::SLT:   d = 32'(sa < sb);
            execPkg::SLTU:  d = 32'(a < b);
            execPkg::XOR:   d = a ^ b;
            execPkg::SRL:   d = a >> b[4:0];
            execPkg::SRA:   d = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : '0);
            execPkg::OR:    d = a | b;
            execPkg::AND:   d = a & b;
            default:        d = '0;
        endcase
        tgt = (op == execPkg::JALR) ? ((a + imm) & 32'hffff_fffe) : pc + imm;
        if (!j)
            tgt = '0;
        return {j, tgt, d};
    endfunction

    task automatic wake(input execPkg::tagT t, input execPkg::dataT v);
        for (int i = 0; i < NumTags; i++) begin
            if (live[i] && !aOk[i] && aW[i] == t) begin
                aOk[i] = 1'b1;
                aV[i]  = v;
            end
            if (live[i] && !bOk[i] && bW[i] == t) begin
                bOk[i] = 1'b1;
                bV[i]  = v;
            end
        end
    endtask

    task automatic checkResult();
        logic [64:0] exp;
        int          t;
        t = int'(resTag);
        if (!live[t]) begin
            if (gone[t])
                $display("Error at %0t: result for tag %0d after it was flushed", $time, t);
            else
                $display("Error at %0t: result for tag %0d with no pending instruction", $time, t);
            failCount++;
        end else if (!aOk[t] || !bOk[t]) begin
            $display("Error at %0t: tag %0d completed before its operands were produced",
                     $time, t);
            failCount++;
        end else begin
            exp = refExec(opS[t], pcS[t], immS[t], aV[t], bV[t]);
            if ({resJump, resTarget, resData} !== exp) begin
                $display("FAIL %0t: tag %0d %s expected data %h jump %b target %h, got %h %b %h",
                         $time, t, opS[t].name(), exp[31:0], exp[64], exp[63:32],
                         resData, resJump, resTarget);
                failCount++;
            end else begin
                passCount++;
            end
            live[t] = 1'b0;
            outstanding--;
        end
    endtask

    // Sampled mid-cycle, acting as the DUT does at the following edge.
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumTags; i++) begin
                live[i] = 1'b0;
                gone[i] = 1'b0;
            end
            outstanding = 0;
        end else begin
            if (resValid && !rdy) begin
                $display("Error at %0t: result bus active while rdy is low", $time);
                failCount++;
            end
            if (resValid)
                checkResult();
            if (dispValid && rdy && !full && !flush) begin
                live[dispTag] = 1'b1;
                gone[dispTag] = 1'b0;
                opS[dispTag]  = dispOp;
                pcS[dispTag]  = dispPc;
                immS[dispTag] = dispImm;
                aOk[dispTag]  = src1Ready;
                aV[dispTag]   = src1Val;
                aW[dispTag]   = src1Tag;
                bOk[dispTag]  = src2Ready;
                bV[dispTag]   = src2Val;
                bW[dispTag]   = src2Tag;
                outstanding++;
            end
            if (resValid)
                wake(resTag, resData);   // Also reaches a same-cycle dispatch.
            if (ldValid && rdy)
                wake(ldTag, ldData);
            if (checkFull) begin
                if (full !== expFull) begin
                    $display("FAIL %0t: full is %b, expected %b", $time, full, expFull);
                    failCount++;
                end else begin
                    passCount++;
                end
            end
            if (flush) begin
                for (int i = 0; i < NumTags; i++) begin
                    if (live[i])
                        gone[i] = 1'b1;
                    live[i] = 1'b0;
                end
                outstanding = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/execCluster.sv ====
`timescale 1ns/10ps
`default_nettype none

module execCluster (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rdy,
    input  wire                 flush,
    input  wire                 dispValid,
    input  wire execPkg::opT    dispOp,
    input  wire execPkg::addrT  dispPc,
    input  wire execPkg::dataT  dispImm,
    input  wire execPkg::tagT   dispTag,
    input  wire                 src1Ready,
    input  wire execPkg::dataT  src1Val,
    input  wire execPkg::tagT   src1Tag,
    input  wire                 src2Ready,
    input  wire execPkg::dataT  src2Val,
    input  wire execPkg::tagT   src2Tag,
    input  wire                 ldValid,
    input  wire execPkg::tagT   ldTag,
    input  wire execPkg::dataT  ldData,
    output wire                 full,
    output wire                 resValid,
    output wire execPkg::tagT   resTag,
    output wire execPkg::dataT  resData,
    output wire                 resJump,
    output wire execPkg::addrT  resTarget
);

    wire                issueValid;
    wire execPkg::opT   issueOp;
    wire execPkg::addrT issuePc;
    wire execPkg::dataT issueImm;
    wire execPkg::tagT  issueTag;
    wire execPkg::dataT issueA;
    wire execPkg::dataT issueB;

    resStation rs0 (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .flush      (flush),
        .dispValid  (dispValid),
        .dispOp     (dispOp),
        .dispPc     (dispPc),
        .dispImm    (dispImm),
        .dispTag    (dispTag),
        .src1Ready  (src1Ready),
        .src1Val    (src1Val),
        .src1Tag    (src1Tag),
        .src2Ready  (src2Ready),
        .src2Val    (src2Val),
        .src2Tag    (src2Tag),
        .resValid   (resValid),   // Own result bus wakes waiting entries.
        .resTag     (resTag),
        .resData    (resData),
        .ldValid    (ldValid),
        .ldTag      (ldTag),
        .ldData     (ldData),
        .full       (full),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issuePc    (issuePc),
        .issueImm   (issueImm),
        .issueTag   (issueTag),
        .issueA     (issueA),
        .issueB     (issueB)
    );

    execUnit ex0 (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .flush      (flush),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issuePc    (issuePc),
        .issueImm   (issueImm),
        .issueTag   (issueTag),
        .issueA     (issueA),
        .issueB     (issueB),
        .resValid   (resValid),
        .resTag     (resTag),
        .resData    (resData),
        .resJump    (resJump),
        .resTarget  (resTarget)
    );

endmodule

`default_nettype wire

// ==== hw/execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_params.svh"

module execUnit (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rdy,
    input  wire                 flush,
    input  wire                 issueValid,
    input  wire execPkg::opT    issueOp,
    input  wire execPkg::addrT  issuePc,
    input  wire execPkg::dataT  issueImm,
    input  wire execPkg::tagT   issueTag,
    input  wire execPkg::dataT  issueA,
    input  wire execPkg::dataT  issueB,
    output logic                resValid,
    output execPkg::tagT        resTag,
    output execPkg::dataT       resData,
    output logic                resJump,
    output execPkg::addrT       resTarget
);

    logic          resValidQ;
    logic [4:0]    shamtI;
    logic [4:0]    shamtR;
    execPkg::addrT brTarget;
    execPkg::addrT linkAddr;
    execPkg::dataT nextData;
    logic          nextJump;
    execPkg::addrT nextTarget;

    assign shamtI   = issueImm[4:0];   // RV32I shifts use five bits.
    assign shamtR   = issueB[4:0];
    assign brTarget = issuePc + issueImm;
    assign linkAddr = issuePc + 32'd4;

    always_comb begin
        nextData   = '0;
        nextJump   = 1'b0;
        nextTarget = brTarget;
        case (issueOp)
            execPkg::LUI:   nextData = issueImm;
            execPkg::AUIPC: nextData = issuePc + issueImm;
            execPkg::JAL: begin
                nextData = linkAddr;
                nextJump = 1'b1;
            end
            execPkg::JALR: begin
                nextData      = linkAddr;
                nextJump      = 1'b1;
                nextTarget    = issueA + issueImm;
                nextTarget[0] = 1'b0;
            end
            execPkg::BEQ:   nextJump = (issueA == issueB);
            execPkg::BNE:   nextJump = (issueA != issueB);
            execPkg::BLT:   nextJump = ($signed(issueA) < $signed(issueB));
            execPkg::BGE:   nextJump = ($signed(issueA) >= $signed(issueB));
            execPkg::BLTU:  nextJump = (issueA < issueB);
            execPkg::BGEU:  nextJump = (issueA >= issueB);
            execPkg::ADDI:  nextData = issueA + issueImm;
            execPkg::SLTI:
                nextData = {{(`DATA_W-1){1'b0}}, $signed(issueA) < $signed(issueImm)};
            execPkg::SLTIU: nextData = {{(`DATA_W-1){1'b0}}, issueA < issueImm};
            execPkg::XORI:  nextData = issueA ^ issueImm;
            execPkg::ORI:   nextData = issueA | issueImm;
            execPkg::ANDI:  nextData = issueA & issueImm;
            execPkg::SLLI:  nextData = issueA << shamtI;
            execPkg::SRLI:  nextData = issueA >> shamtI;
            execPkg::SRAI:  nextData = $signed(issueA) >>> shamtI;
            execPkg::ADD:   nextData = issueA + issueB;
            execPkg::SUB:   nextData = issueA - issueB;
            execPkg::SLL:   nextData = issueA << shamtR;
            execPkg::SLT:
                nextData = {{(`DATA_W-1){1'b0}}, $signed(issueA) < $signed(issueB)};
            execPkg::SLTU:  nextData = {{(`DATA_W-1){1'b0}}, issueA < issueB};
            execPkg::XOR:   nextData = issueA ^ issueB;
            execPkg::SRL:   nextData = issueA >> shamtR;
            execPkg::SRA:   nextData = $signed(issueA) >>> shamtR;
            execPkg::OR:    nextData = issueA | issueB;
            execPkg::AND:   nextData = issueA & issueB;
            default:        nextData = '0;
        endcase
        if (!nextJump)
            nextTarget = '0;   // No target unless taken.
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            resValidQ <= 1'b0;
        end else if (rdy) begin
            resValidQ <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueValid) begin
            resTag    <= issueTag;
            resData   <= nextData;
            resJump   <= nextJump;
            resTarget <= nextTarget;
        end
    end

    // A pending result is held through a pause and shown once rdy returns.
    assign resValid = resValidQ & rdy;

endmodule

`default_nettype wire

// ==== hw/resStation.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_params.svh"

module resStation (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rdy,
    input  wire                 flush,
    input  wire                 dispValid,
    input  wire execPkg::opT    dispOp,
    input  wire execPkg::addrT  dispPc,
    input  wire execPkg::dataT  dispImm,
    input  wire execPkg::tagT   dispTag,
    input  wire                 src1Ready,
    input  wire execPkg::dataT  src1Val,
    input  wire execPkg::tagT   src1Tag,
    input  wire                 src2Ready,
    input  wire execPkg::dataT  src2Val,
    input  wire execPkg::tagT   src2Tag,
    input  wire                 resValid,
    input  wire execPkg::tagT   resTag,
    input  wire execPkg::dataT  resData,
    input  wire                 ldValid,
    input  wire execPkg::tagT   ldTag,
    input  wire execPkg::dataT  ldData,
    output logic                full,
    output logic                issueValid,
    output execPkg::opT         issueOp,
    output execPkg::addrT       issuePc,
    output execPkg::dataT       issueImm,
    output execPkg::tagT        issueTag,
    output execPkg::dataT       issueA,
    output execPkg::dataT       issueB
);

    localparam int IdxW = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0] entValid;
    logic [`RS_DEPTH-1:0] entReady;
    logic [`RS_DEPTH-1:0] aReady;
    logic [`RS_DEPTH-1:0] bReady;
    execPkg::opT          entOp  [`RS_DEPTH];
    execPkg::addrT        entPc  [`RS_DEPTH];
    execPkg::dataT        entImm [`RS_DEPTH];
    execPkg::tagT         entTag [`RS_DEPTH];
    execPkg::dataT        aVal   [`RS_DEPTH];
    execPkg::dataT        bVal   [`RS_DEPTH];
    execPkg::tagT         aTag   [`RS_DEPTH];
    execPkg::tagT         bTag   [`RS_DEPTH];
    logic [IdxW-1:0]      issueIdx;
    logic [IdxW-1:0]      freeIdx;
    logic                 dispWrite;
    logic [`DATA_W:0]     dispA;
    logic [`DATA_W:0]     dispB;

    // Returns {ready, value} after looking at both broadcast ports.
    function automatic logic [`DATA_W:0] snoop(input logic haveIt,
                                               input execPkg::dataT val,
                                               input execPkg::tagT waitTag);
        if (haveIt)
            return {1'b1, val};
        if (resValid && waitTag == resTag)
            return {1'b1, resData};
        if (ldValid && waitTag == ldTag)
            return {1'b1, ldData};
        return {1'b0, val};
    endfunction

    assign entReady   = entValid & aReady & bReady;
    assign full       = &entValid;
    assign issueValid = rdy & (|entReady);
    assign dispWrite  = rdy & dispValid & ~full;   // Strobe while full is dropped.

    // Operands of an incoming instruction may be woken in the same cycle.
    always_comb begin
        dispA = snoop(src1Ready, src1Val, src1Tag);
        dispB = snoop(src2Ready, src2Val, src2Tag);
    end

    // Lowest index wins for both issue and allocation.
    always_comb begin
        issueIdx = '0;
        freeIdx  = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (entReady[i])
                issueIdx = IdxW'(i);
            if (!entValid[i])
                freeIdx = IdxW'(i);
        end
    end

    assign issueOp  = entOp[issueIdx];
    assign issuePc  = entPc[issueIdx];
    assign issueImm = entImm[issueIdx];
    assign issueTag = entTag[issueIdx];
    assign issueA   = aVal[issueIdx];
    assign issueB   = bVal[issueIdx];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entValid <= '0;
        end else if (rdy) begin
            if (issueValid)
                entValid[issueIdx] <= 1'b0;   // Freed on issue.
            if (dispWrite)
                entValid[freeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (dispWrite && freeIdx == IdxW'(i)) begin
                    entOp[i]              <= dispOp;
                    entPc[i]              <= dispPc;
                    entImm[i]             <= dispImm;
                    entTag[i]             <= dispTag;
                    {aReady[i], aVal[i]}  <= dispA;
                    {bReady[i], bVal[i]}  <= dispB;
                    aTag[i]               <= src1Tag;
                    bTag[i]               <= src2Tag;
                end else if (entValid[i]) begin
                    {aReady[i], aVal[i]} <= snoop(aReady[i], aVal[i], aTag[i]);
                    {bReady[i], bVal[i]} <= snoop(bReady[i], bVal[i], bTag[i]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/execPkg.sv ====
`default_nettype none

`include "exec_params.svh"

package execPkg;

    typedef logic [`DATA_W-1:0] dataT;   // Operand, immediate or result.
    typedef logic [31:0]        addrT;   // Instruction address.
    typedef logic [`TAG_W-1:0]  tagT;    // Rename tag of the producer.

    // Integer operations handled by the slice.
    typedef enum logic [4:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } opT;

endpackage

`default_nettype wire

// ==== hw/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Operand and result width.
`define DATA_W 32

// Rename tag width, sixteen tags in flight.
`define TAG_W 4

// Reservation station entries.
`define RS_DEPTH 4

`endif
